//--- source/omem_addr_gen.sv
`timescale 1ns/1ps

module omem_addr_gen (
   input  logic               clk,
   input  logic               rst,
   input  logic               run_i,
   input  omem_pkg::agu_cfg_t cfg_i,
   input  logic               credit_ok_i,
   output omem_pkg::mem_rd_t  rd_o,
   output logic               last_o
);
   import omem_pkg::*;

   agu_state_t state_q;
   agu_cfg_t   cfg_q;
   delay_t     delay_cnt_q;
   period_t    inner_q;
   addr_t      outer_q;
   addr_t      base_q;
   addr_t      addr_q;

   logic start;
   logic fire;
   logic inner_end;
   logic outer_end;
   logic run_empty;
   logic cfg_empty;

   assign start     = (state_q == IDLE) && run_i;
   assign run_empty = (cfg_i.iterations == '0) || (cfg_i.period == '0);
   assign cfg_empty = (cfg_q.iterations == '0) || (cfg_q.period == '0);

   assign fire      = (state_q == ISSUE) && credit_ok_i;
   assign inner_end = (inner_q == cfg_q.period - 1'b1);
   assign outer_end = (outer_q == cfg_q.iterations - 1'b1);

   assign rd_o.en   = fire;
   assign rd_o.addr = addr_q;

   // empty runs still send a last marker so done can follow
   assign last_o = (fire && inner_end && outer_end) ||
                   ((state_q == FINISH) && cfg_empty);

   always_ff @(posedge clk) begin
      if (start) begin
         cfg_q <= cfg_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q     <= IDLE;
         delay_cnt_q <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (run_i) begin
                  if (run_empty) begin
                     state_q <= FINISH;
                  end else if (cfg_i.delay == '0) begin
                     state_q <= ISSUE;
                  end else begin
                     state_q     <= DELAY;
                     delay_cnt_q <= cfg_i.delay - 1'b1;
                  end
               end
            end
            DELAY: begin
               if (delay_cnt_q == '0) begin
                  state_q <= ISSUE;
               end else begin
                  delay_cnt_q <= delay_cnt_q - 1'b1;
               end
            end
            ISSUE: begin
               if (fire && inner_end && outer_end) begin
                  state_q <= FINISH;
               end
            end
            FINISH: begin
               state_q <= IDLE;
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // running sums replace i*shift + j*incr, wrap is free at 10 bits
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         inner_q <= '0;
         outer_q <= '0;
         base_q  <= '0;
         addr_q  <= '0;
      end else if (start) begin
         inner_q <= '0;
         outer_q <= '0;
         base_q  <= cfg_i.start;
         addr_q  <= cfg_i.start;
      end else if (fire) begin
         if (inner_end) begin
            inner_q <= '0;
            outer_q <= outer_q + 1'b1;
            base_q  <= base_q + cfg_q.shift;
            addr_q  <= base_q + cfg_q.shift;
         end else begin
            inner_q <= inner_q + 1'b1;
            addr_q  <= addr_q + cfg_q.incr;
         end
      end
   end

endmodule

//--- source/omem_bus_port.sv
`timescale 1ns/1ps

module omem_bus_port (
   input  logic               clk,
   input  logic               rst,
   input  omem_pkg::bus_req_t bus_req_i,
   output omem_pkg::mem_wr_t  wr_o,
   output logic               ack_o
);
   import omem_pkg::*;

   logic  wr_en_q;
   logic  ack_q;
   addr_t addr_q;
   data_t data_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en_q <= 1'b0;
         ack_q   <= 1'b0;
      end else begin
         // strobes only qualify the write, whole words are stored
         wr_en_q <= bus_req_i.valid & (|bus_req_i.wstrb);
         ack_q   <= bus_req_i.valid;
      end
   end

   always_ff @(posedge clk) begin
      addr_q <= bus_req_i.addr;
      data_q <= bus_req_i.wdata;
   end

   assign wr_o.en   = wr_en_q;
   assign wr_o.addr = addr_q;
   assign wr_o.data = data_q;
   assign ack_o     = ack_q;

endmodule

//--- source/omem_pkg.sv
package omem_pkg;

   localparam int OMEM_ADDR_W = 10;
   localparam int OMEM_DATA_W = 32;

   typedef logic [OMEM_ADDR_W-1:0]   addr_t;
   typedef logic [OMEM_DATA_W-1:0]   data_t;
   typedef logic [OMEM_DATA_W/8-1:0] strb_t;
   typedef logic [9:0]               period_t;
   typedef logic [31:0]              delay_t;

   // two-level pattern config of 82 bits
   typedef struct packed {
      addr_t   iterations;
      period_t period;
      addr_t   start;
      addr_t   incr;
      addr_t   shift;
      delay_t  delay;
   } agu_cfg_t;

   typedef struct packed {
      logic  valid;
      strb_t wstrb;
      addr_t addr;
      data_t wdata;
   } bus_req_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
      data_t data;
   } mem_wr_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
   } mem_rd_t;

   typedef enum logic [1:0] {
      IDLE,
      DELAY,
      ISSUE,
      FINISH
   } agu_state_t;

endpackage

//--- source/omem_ram_2p.sv
`timescale 1ns/1ps

module omem_ram_2p (
   input  logic              clk,
   input  omem_pkg::mem_wr_t wr_i,
   input  omem_pkg::mem_rd_t rd_i,
   output omem_pkg::data_t   rdata_o
);
   import omem_pkg::*;

   localparam int DEPTH = 2 ** OMEM_ADDR_W;

   data_t mem [DEPTH];
   data_t rdata_q;

   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // old data on a same-cycle collision
   always_ff @(posedge clk) begin
      if (rd_i.en) begin
         rdata_q <= mem[rd_i.addr];
      end
   end

   assign rdata_o = rdata_q;

endmodule

//--- source/omem_stream_out.sv
`timescale 1ns/1ps

module omem_stream_out #(
   parameter int CREDIT_MAX = 4
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            rd_en_i,
   input  logic            last_i,
   input  logic            run_i,
   input  omem_pkg::data_t rdata_i,
   input  logic            credit_i,
   output logic            credit_ok_o,
   output omem_pkg::data_t out_data_o,
   output logic            out_valid_o,
   output logic            done_o
);
   import omem_pkg::*;

   localparam int CNT_W = $clog2(CREDIT_MAX + 1);

   typedef logic [CNT_W-1:0] credit_t;

   credit_t    credit_cnt_q;
   logic [1:0] valid_q;
   logic [1:0] last_q;
   data_t      data_q;
   logic       done_q;

   assign credit_ok_o = (credit_cnt_q != '0);

   // return and spend may coincide
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         credit_cnt_q <= credit_t'(CREDIT_MAX);
      end else begin
         case ({credit_i, rd_en_i})
            2'b10:   credit_cnt_q <= credit_cnt_q + 1'b1;
            2'b01:   credit_cnt_q <= credit_cnt_q - 1'b1;
            default: credit_cnt_q <= credit_cnt_q;
         endcase
      end
   end

   // bit 0 lines up with ram data, bit 1 with the output register
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= '0;
         last_q  <= '0;
      end else begin
         valid_q <= {valid_q[0], rd_en_i};
         last_q  <= {last_q[0], last_i};
      end
   end

   always_ff @(posedge clk) begin
      if (valid_q[0]) begin
         data_q <= rdata_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q <= 1'b0;
      end else if (run_i) begin
         done_q <= 1'b0;
      end else if (last_q[1]) begin
         done_q <= 1'b1;
      end
   end

   assign out_valid_o = valid_q[1];
   assign out_data_o  = valid_q[1] ? data_q : '0;
   assign done_o      = done_q;

endmodule

//--- source/omem_top.sv
`timescale 1ns/1ps

module omem_top #(
   parameter int CREDIT_MAX = 4
) (
   input  logic               clk,
   input  logic               rst,
   input  omem_pkg::bus_req_t bus_req_i,
   output logic               ack_o,
   input  logic               run_i,
   input  omem_pkg::agu_cfg_t cfg_i,
   input  logic               credit_i,
   output omem_pkg::data_t    out_data_o,
   output logic               out_valid_o,
   output logic               done_o
);
   import omem_pkg::*;

   mem_wr_t wr;
   mem_rd_t rd;
   data_t   rdata;
   logic    last;
   logic    credit_ok;

   omem_bus_port bus_port_inst (
      .clk       (clk),
      .rst       (rst),
      .bus_req_i (bus_req_i),
      .wr_o      (wr),
      .ack_o     (ack_o)
   );

   omem_addr_gen addr_gen_inst (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .cfg_i       (cfg_i),
      .credit_ok_i (credit_ok),
      .rd_o        (rd),
      .last_o      (last)
   );

   omem_ram_2p ram_inst (
      .clk     (clk),
      .wr_i    (wr),
      .rd_i    (rd),
      .rdata_o (rdata)
   );

   omem_stream_out #(
      .CREDIT_MAX (CREDIT_MAX)
   ) stream_out_inst (
      .clk         (clk),
      .rst         (rst),
      .rd_en_i     (rd.en),
      .last_i      (last),
      .run_i       (run_i),
      .rdata_i     (rdata),
      .credit_i    (credit_i),
      .credit_ok_o (credit_ok),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .done_o      (done_o)
   );

endmodule

//--- sources.f
source/omem_pkg.sv
source/omem_bus_port.sv
source/omem_addr_gen.sv
source/omem_ram_2p.sv
source/omem_stream_out.sv
source/omem_top.sv
tb/omem_props.sv
tb/omem_tb.sv

//--- tb/omem_props.sv
`timescale 1ns/1ps

module omem_props #(
   parameter int CREDIT_MAX = 4
) (
   input logic                                clk,
   input logic                                rst,
   input omem_pkg::bus_req_t                  bus_req_i,
   input logic                                ack_i,
   input logic [$clog2(CREDIT_MAX + 1)-1:0]   credit_cnt_i,
   input omem_pkg::agu_state_t                state_i,
   input omem_pkg::data_t                     out_data_i,
   input logic                                out_valid_i,
   input logic                                done_i
);
   import omem_pkg::*;

   int fail_count = 0;

   ack_follows_req: assert property (@(posedge clk) disable iff (rst)
      bus_req_i.valid |=> ack_i)
   else begin
      fail_count++;
      $error("ack_o missing one cycle after a host request");
   end

   ack_only_after_req: assert property (@(posedge clk) disable iff (rst)
      !bus_req_i.valid |=> !ack_i)
   else begin
      fail_count++;
      $error("ack_o high without a host request");
   end

   credit_in_range: assert property (@(posedge clk) disable iff (rst)
      credit_cnt_i <= CREDIT_MAX)
   else begin
      fail_count++;
      $error("credit counter above its maximum");
   end

   reset_state: assert property (@(posedge clk)
      (rst && $past(rst)) |-> (!out_valid_i && !ack_i && !done_i && state_i == IDLE))
   else begin
      fail_count++;
      $error("outputs or generator state not cleared during reset");
   end

   after_reset: assert property (@(posedge clk)
      $fell(rst) |-> (!out_valid_i && !ack_i && !done_i))
   else begin
      fail_count++;
      $error("outputs not low in the cycle after reset");
   end

   data_zero_idle: assert property (@(posedge clk) disable iff (rst)
      !out_valid_i |-> (out_data_i == '0))
   else begin
      fail_count++;
      $error("out_data_o not zero while out_valid_o is low");
   end

endmodule

bind omem_top omem_props #(
   .CREDIT_MAX (CREDIT_MAX)
) props_inst (
   .clk          (clk),
   .rst          (rst),
   .bus_req_i    (bus_req_i),
   .ack_i        (ack_o),
   .credit_cnt_i (stream_out_inst.credit_cnt_q),
   .state_i      (addr_gen_inst.state_q),
   .out_data_i   (out_data_o),
   .out_valid_i  (out_valid_o),
   .done_i       (done_o)
);

//--- tb/omem_tb.sv
`timescale 1ns/1ps

module omem_tb;
   import omem_pkg::*;

   localparam int CREDIT_MAX = 4;
   localparam int DEPTH      = 2 ** OMEM_ADDR_W;
   // fill is about 1030 cycles, the three runs about 150 more
   localparam int TIMEOUT_CYCLES = 4000;

   logic     clk;
   logic     rst;
   bus_req_t bus_req;
   logic     ack;
   logic     run;
   agu_cfg_t cfg;
   logic     credit;
   data_t    out_data;
   logic     out_valid;
   logic     done;

   data_t mem_model [DEPTH];
   data_t exp_q [$];
   int    due_q [$];
   data_t exp_word;
   int    cycle_cnt = 0;
   int    err_count = 0;
   int    words_total = 0;
   int    credits_total = 0;
   int    words_in_run = 0;
   int    exp_words = 0;
   int    run_cycle = 0;
   int    cur_delay = 0;
   logic  hold = 1'b0;
   logic  first_pending = 1'b0;
   logic  done_seen = 1'b0;
   logic  run_prev = 1'b0;
   logic  done_prev = 1'b0;

   omem_top #(
      .CREDIT_MAX (CREDIT_MAX)
   ) omem_top_inst (
      .clk         (clk),
      .rst         (rst),
      .bus_req_i   (bus_req),
      .ack_o       (ack),
      .run_i       (run),
      .cfg_i       (cfg),
      .credit_i    (credit),
      .out_data_o  (out_data),
      .out_valid_o (out_valid),
      .done_o      (done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   function automatic data_t word_hash(input addr_t a);
      return (data_t'(a ^ 10'h2b7) << 13) ^ data_t'(a);
   endfunction

   function automatic agu_cfg_t build_cfg(input int iters, input int per, input int start,
                                          input int incr, input int shift, input int dly);
      agu_cfg_t c;
      c.iterations = addr_t'(iters);
      c.period     = period_t'(per);
      c.start      = addr_t'(start);
      c.incr       = addr_t'(incr);
      c.shift      = addr_t'(shift);
      c.delay      = delay_t'(dly);
      return c;
   endfunction

   task automatic write_req(input addr_t a, input data_t d, input strb_t s);
      @(posedge clk);
      bus_req.valid <= 1'b1;
      bus_req.wstrb <= s;
      bus_req.addr  <= a;
      bus_req.wdata <= d;
      if (|s) begin
         mem_model[a] = d;
      end
   endtask

   task automatic fill_memory();
      int n;
      for (n = 0; n < DEPTH; n++) begin
         write_req(addr_t'(n), word_hash(addr_t'(n)), '1);
      end
   endtask

   task automatic run_pattern(input agu_cfg_t c, input int hold_cycles);
      int unsigned a;
      int i;
      int j;
      exp_q.delete();
      for (i = 0; i < c.iterations; i++) begin
         for (j = 0; j < c.period; j++) begin
            a = c.start + i * c.shift + j * c.incr;
            exp_q.push_back(mem_model[a % DEPTH]);
         end
      end
      exp_words = c.iterations * c.period;
      cur_delay = c.delay;
      done_seen = 1'b0;
      @(posedge clk);
      run <= 1'b1;
      cfg <= c;
      if (hold_cycles > 0) begin
         hold <= 1'b1;
      end
      @(posedge clk);
      run <= 1'b0;
      if (hold_cycles > 0) begin
         repeat (hold_cycles - 1) @(posedge clk);
         // every granted credit spent, nothing beyond
         assert (words_total - credits_total == CREDIT_MAX)
         else begin
            err_count++;
            $display("[ERROR] outstanding words expected %h got %h",
                     CREDIT_MAX, words_total - credits_total);
         end
         hold <= 1'b0;
      end
      while (!done_seen) @(posedge clk);
      assert (exp_q.size() == 0)
      else begin
         err_count++;
         $display("done_o rose while %0d words were still missing", exp_q.size());
      end
      while (words_total != credits_total) @(posedge clk);
   endtask

   // consumer returns one credit per word after a short random wait
   always @(posedge clk) begin
      if (!hold && due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
         credit <= 1'b1;
         void'(due_q.pop_front());
      end else begin
         credit <= 1'b0;
      end
   end

   always @(negedge clk) begin
      if (!rst) begin
         if (run) begin
            run_cycle     = cycle_cnt;
            first_pending = 1'b1;
            words_in_run  = 0;
         end
         if (run_prev) begin
            assert (!done)
            else begin
               err_count++;
               $display("done_o still high after run_i");
            end
         end
         if (out_valid) begin
            if (first_pending) begin
               assert (cycle_cnt - run_cycle >= cur_delay + 3)
               else begin
                  err_count++;
                  $display("first word came %0d cycles after run_i, before the delay ran out",
                           cycle_cnt - run_cycle);
               end
            end
            first_pending = 1'b0;
            assert (exp_q.size() > 0)
            else begin
               err_count++;
               $display("out_valid_o high with no word left in the pattern");
            end
            if (exp_q.size() > 0) begin
               exp_word = exp_q.pop_front();
               assert (out_data == exp_word)
               else begin
                  err_count++;
                  $display("[ERROR] out_data_o expected %h got %h", exp_word, out_data);
               end
            end
            words_in_run++;
            words_total++;
            due_q.push_back(cycle_cnt + 1 + ($urandom % 4));
         end
         if (credit) begin
            credits_total++;
         end
         assert (words_total - credits_total <= CREDIT_MAX)
         else begin
            err_count++;
            $display("more words outstanding than credits granted");
         end
         if (done && !done_prev) begin
            assert (words_in_run == exp_words)
            else begin
               err_count++;
               $display("[ERROR] words before done_o expected %h got %h",
                        exp_words, words_in_run);
            end
            done_seen = 1'b1;
         end
         run_prev  = run;
         done_prev = done;
      end
   end

   initial begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
   end

   initial begin
      void'($urandom(32'hc885_4945));
      rst     = 1'b1;
      bus_req = '0;
      run     = 1'b0;
      cfg     = '0;
      credit  = 1'b0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      fill_memory();
      // strobe-less request must not change word 5
      write_req(addr_t'(5), 32'hdead_beef, '0);
      @(posedge clk);
      bus_req <= '0;
      repeat (4) @(posedge clk);
      run_pattern(build_cfg(1, 16, 0, 1, 0, 0), 0);
      run_pattern(build_cfg(4, 6, 1000, 7, 33, 2), 20);
      run_pattern(build_cfg(0, 8, 12, 1, 0, 5), 0);
      repeat (4) @(posedge clk);
      $display("summary: %0d testbench errors, %0d property errors",
               err_count, omem_top_inst.props_inst.fail_count);
      if (err_count == 0 && omem_top_inst.props_inst.fail_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
